// ==== Makefile ====
# Verilator build and run for the issue subsystem testbench

VERILATOR ?= verilator
TOP       ?= ooo_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables (override on the command line):"
	@echo "  VERILATOR=$(VERILATOR) TOP=$(TOP) FILELIST=$(FILELIST)"
	@echo "  OBJ_DIR=$(OBJ_DIR) VFLAGS=\"$(VFLAGS)\""

# The run fails with a non-zero status when the testbench stops on $$fatal
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+include
logic/ooo_pkg.sv
logic/rs_dispatch.sv
logic/reservation_station.sv
logic/issue_select.sv
logic/alu_exec.sv
logic/ooo_issue_top.sv
dv/ooo_tb.sv

// ==== dv/ooo_tb.sv ====
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_tb;

  localparam int CLK_PERIOD = 10;
  localparam int N_TAGS = 1 << `OOO_TAG_W;
  localparam logic [1:0] SRC_NONE = 2'd0;
  localparam logic [1:0] SRC_READY = 2'd1;
  localparam logic [1:0] SRC_WAIT = 2'd2;
  localparam logic [`OOO_TAG_W-1:0] NO_HEAD = '1;

  typedef struct packed {
    logic [1:0]            kind;
    logic [`OOO_TAG_W-1:0] tag;
  } src_desc_t;

  // One table row is one clock cycle of stimulus
  typedef struct packed {
    logic                   dv;
    ooo_pkg::alu_op_e       op;
    src_desc_t              s1;
    src_desc_t              s2;
    logic                   ser;
    logic [`OOO_TAG_W-1:0]  head;
    logic                   flush;
    logic                   exp_stall;
    logic [`OOO_TAG_W-1:0]  exp_tag;
    logic [`OOO_DATA_W-1:0] exp_value;
    int                     lat;
    ooo_pkg::dispatch_t     disp;
  } row_t;

  logic                  clk;
  logic                  rst_n;
  logic                  flush;
  logic                  dispatch_valid;
  ooo_pkg::dispatch_t    dispatch_in;
  logic                  serialize;
  logic [`OOO_TAG_W-1:0] head_tag;
  logic                  stall;
  ooo_pkg::cdb_t         cdb [`OOO_CDB_W];

  row_t                   rows[$];
  int                     table_len = 0;
  logic [31:0]            lfsr_q = 32'he5f8_5812;
  logic [`OOO_DATA_W-1:0] model_val [N_TAGS];
  logic [`OOO_DATA_W-1:0] exp_val [N_TAGS];
  logic                   exp_live [N_TAGS];
  int                     exp_seen [N_TAGS];
  int                     exp_lat [N_TAGS];
  int                     disp_row [N_TAGS];
  int                     pending = 0;
  logic                   prev_ser = 1'b0;
  logic [`OOO_TAG_W-1:0]  prev_head = '0;

  ooo_issue_top dut_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .dispatch_valid(dispatch_valid), .dispatch_in(dispatch_in),
    .serialize(serialize), .head_tag(head_tag),
    .stall(stall), .cdb(cdb)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  initial begin
    wait (table_len > 0);
    #(table_len * 20 * CLK_PERIOD);
    abort_run("Timeout: results did not drain within the cycle budget");
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [`OOO_DATA_W-1:0] ref_result(input ooo_pkg::alu_op_e op,
                                                         input logic [`OOO_DATA_W-1:0] a,
                                                         input logic [`OOO_DATA_W-1:0] b);
    case (op)
      ooo_pkg::ALU_ADD: return a + b;
      ooo_pkg::ALU_SUB: return a - b;
      ooo_pkg::ALU_AND: return a & b;
      ooo_pkg::ALU_OR:  return a | b;
      ooo_pkg::ALU_XOR: return a ^ b;
      ooo_pkg::ALU_SLL: return a << b[4:0];
      ooo_pkg::ALU_SRL: return a >> b[4:0];
      ooo_pkg::ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      default:          return '0;
    endcase
  endfunction

  function automatic src_desc_t ready_src();
    return '{kind: SRC_READY, tag: '0};
  endfunction

  function automatic src_desc_t absent_src();
    return '{kind: SRC_NONE, tag: '0};
  endfunction

  function automatic src_desc_t wait_src(input logic [`OOO_TAG_W-1:0] t);
    return '{kind: SRC_WAIT, tag: t};
  endfunction

  task automatic op_row(input ooo_pkg::alu_op_e op, input src_desc_t s1, input src_desc_t s2,
                        input logic ser, input logic [`OOO_TAG_W-1:0] head,
                        input logic [`OOO_TAG_W-1:0] tag, input int lat);
    row_t r;
    r = '0;
    r.dv = 1'b1;
    r.op = op;
    r.s1 = s1;
    r.s2 = s2;
    r.ser = ser;
    r.head = head;
    r.exp_tag = tag;
    r.lat = lat;
    rows.push_back(r);
  endtask

  task automatic idle_row(input logic ser, input logic [`OOO_TAG_W-1:0] head,
                          input logic fl, input logic exp_stall);
    row_t r;
    r = '0;
    r.s1 = absent_src();
    r.s2 = absent_src();
    r.ser = ser;
    r.head = head;
    r.flush = fl;
    r.exp_stall = exp_stall;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Every opcode on independent operands, then one with rs2 absent
    op_row(ooo_pkg::ALU_ADD, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd0, 2);
    op_row(ooo_pkg::ALU_SUB, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd1, 2);
    op_row(ooo_pkg::ALU_AND, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd2, 2);
    op_row(ooo_pkg::ALU_OR, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd3, 2);
    op_row(ooo_pkg::ALU_XOR, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd4, 2);
    op_row(ooo_pkg::ALU_SLL, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd5, 2);
    op_row(ooo_pkg::ALU_SRL, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd6, 2);
    op_row(ooo_pkg::ALU_SLT, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd7, 2);
    op_row(ooo_pkg::ALU_ADD, ready_src(), absent_src(), 1'b0, NO_HEAD, 6'd8, 2);
    // Chains; tag 11 is written while tag 9 is on the CDB
    op_row(ooo_pkg::ALU_ADD, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd9, 2);
    op_row(ooo_pkg::ALU_SUB, wait_src(6'd9), ready_src(), 1'b0, NO_HEAD, 6'd10, 3);
    op_row(ooo_pkg::ALU_XOR, ready_src(), wait_src(6'd9), 1'b0, NO_HEAD, 6'd11, 2);
    op_row(ooo_pkg::ALU_OR, wait_src(6'd10), wait_src(6'd11), 1'b0, NO_HEAD, 6'd12, 3);
    op_row(ooo_pkg::ALU_SLL, wait_src(6'd12), ready_src(), 1'b0, NO_HEAD, 6'd13, 4);
    repeat (3) idle_row(1'b0, NO_HEAD, 1'b0, 1'b0);
    // Producer held by serialize, seven waiting consumers fill the station
    op_row(ooo_pkg::ALU_ADD, ready_src(), ready_src(), 1'b1, NO_HEAD, 6'd14, 0);
    op_row(ooo_pkg::ALU_SUB, wait_src(6'd14), ready_src(), 1'b1, NO_HEAD, 6'd15, 0);
    op_row(ooo_pkg::ALU_AND, wait_src(6'd14), ready_src(), 1'b1, NO_HEAD, 6'd16, 0);
    op_row(ooo_pkg::ALU_OR, wait_src(6'd14), ready_src(), 1'b1, NO_HEAD, 6'd17, 0);
    op_row(ooo_pkg::ALU_XOR, wait_src(6'd14), ready_src(), 1'b1, NO_HEAD, 6'd18, 0);
    op_row(ooo_pkg::ALU_SLL, wait_src(6'd14), ready_src(), 1'b1, NO_HEAD, 6'd19, 0);
    op_row(ooo_pkg::ALU_SRL, wait_src(6'd14), wait_src(6'd15), 1'b1, NO_HEAD, 6'd20, 0);
    op_row(ooo_pkg::ALU_SLT, wait_src(6'd14), ready_src(), 1'b1, NO_HEAD, 6'd21, 0);
    idle_row(1'b1, NO_HEAD, 1'b0, 1'b1);
    idle_row(1'b0, NO_HEAD, 1'b0, 1'b1);
    // Ninth dispatch takes entry 0 as soon as the producer leaves
    op_row(ooo_pkg::ALU_ADD, wait_src(6'd21), ready_src(), 1'b0, NO_HEAD, 6'd22, 0);
    idle_row(1'b0, NO_HEAD, 1'b0, 1'b1);
    repeat (5) idle_row(1'b0, NO_HEAD, 1'b0, 1'b0);
    // Serialize lets the head tag through, 24 then 23, then 25 after release
    op_row(ooo_pkg::ALU_AND, ready_src(), ready_src(), 1'b1, NO_HEAD, 6'd23, 0);
    op_row(ooo_pkg::ALU_OR, ready_src(), ready_src(), 1'b1, NO_HEAD, 6'd24, 0);
    op_row(ooo_pkg::ALU_XOR, ready_src(), ready_src(), 1'b1, 6'd24, 6'd25, 0);
    idle_row(1'b1, 6'd23, 1'b0, 1'b0);
    idle_row(1'b0, NO_HEAD, 1'b0, 1'b0);
    // Flush while two entries issue and one waits on a tag that never comes
    op_row(ooo_pkg::ALU_ADD, ready_src(), ready_src(), 1'b1, NO_HEAD, 6'd26, 0);
    op_row(ooo_pkg::ALU_SUB, ready_src(), ready_src(), 1'b1, NO_HEAD, 6'd27, 0);
    op_row(ooo_pkg::ALU_AND, wait_src(6'd62), ready_src(), 1'b1, NO_HEAD, 6'd28, 0);
    idle_row(1'b0, NO_HEAD, 1'b1, 1'b0);
    op_row(ooo_pkg::ALU_SRL, ready_src(), ready_src(), 1'b0, NO_HEAD, 6'd29, 2);
    op_row(ooo_pkg::ALU_SLT, wait_src(6'd29), ready_src(), 1'b0, NO_HEAD, 6'd30, 3);
    op_row(ooo_pkg::ALU_SUB, absent_src(), wait_src(6'd30), 1'b0, NO_HEAD, 6'd31, 4);
  endtask

  task automatic build_src(input src_desc_t d, output ooo_pkg::src_t s,
                           output logic [`OOO_DATA_W-1:0] opnd);
    s = '0;
    s.ready = 1'b1;
    if (d.kind == SRC_READY) begin
      s.value = take_bits(32);
    end else if (d.kind == SRC_WAIT) begin
      // Junk value, replaced by the CDB capture
      s.value = 32'hdead_beef;
      s.tag = d.tag;
      s.ready = 1'b0;
    end
    opnd = (d.kind == SRC_WAIT) ? model_val[d.tag] : s.value;
  endtask

  // Reference model: operand values, dispatch payload and result per tag
  task automatic prepare_expected();
    row_t                   r;
    logic [`OOO_DATA_W-1:0] a;
    logic [`OOO_DATA_W-1:0] b;
    for (int t = 0; t < N_TAGS; t++) begin
      model_val[t] = '0;
      exp_live[t] = 1'b0;
      exp_seen[t] = 0;
    end
    for (int i = 0; i < rows.size(); i++) begin
      r = rows[i];
      if (r.dv) begin
        r.disp.uop.op = r.op;
        r.disp.uop.has_rs1 = (r.s1.kind != SRC_NONE);
        r.disp.uop.has_rs2 = (r.s2.kind != SRC_NONE);
        build_src(r.s1, r.disp.src1, a);
        build_src(r.s2, r.disp.src2, b);
        r.exp_value = ref_result(r.op, a, b);
        model_val[r.exp_tag] = r.exp_value;
        rows[i] = r;
      end
    end
  endtask

  task automatic apply_row(input row_t r, input int cyc);
    dispatch_valid = r.dv;
    dispatch_in = r.dv ? r.disp : '0;
    serialize = r.ser;
    head_tag = r.head;
    flush = r.flush;
    if (r.dv) begin
      exp_live[r.exp_tag] = 1'b1;
      exp_seen[r.exp_tag] = 0;
      exp_val[r.exp_tag] = r.exp_value;
      exp_lat[r.exp_tag] = r.lat;
      disp_row[r.exp_tag] = cyc;
      pending++;
    end
  endtask

  task automatic check_stall(input logic got, input logic exp, input int cyc);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t: stall is %b in cycle %0d, expected %b",
                          $time, got, cyc, exp));
    end
  endtask

  task automatic check_cdb(input ooo_pkg::cdb_t got, input int cyc);
    if (!got.valid) begin
      return;
    end
    if (prev_ser && (got.tag != prev_head)) begin
      abort_run($sformatf("Serialize mode let tag %0d issue while the head tag was %0d",
                          got.tag, prev_head));
    end else if (!exp_live[got.tag]) begin
      abort_run($sformatf("CDB carried tag %0d, which has no result outstanding", got.tag));
    end else if (got.value !== exp_val[got.tag]) begin
      abort_run($sformatf("[ERROR] %0t: tag %0d value %h, expected %h",
                          $time, got.tag, got.value, exp_val[got.tag]));
    end else if ((exp_lat[got.tag] != 0) && (cyc - disp_row[got.tag] != exp_lat[got.tag])) begin
      abort_run($sformatf("[ERROR] %0t: tag %0d arrived %0d cycles after dispatch, expected %0d",
                          $time, got.tag, cyc - disp_row[got.tag], exp_lat[got.tag]));
    end else begin
      if (exp_seen[got.tag] == 0) begin
        pending--;
      end
      exp_seen[got.tag]++;
    end
  endtask

  task automatic sample_lanes(input int cyc);
    for (int k = 0; k < `OOO_CDB_W; k++) begin
      check_cdb(cdb[k], cyc);
    end
  endtask

  // Anything still outstanding at a flush is lost
  task automatic drop_pending();
    for (int t = 0; t < N_TAGS; t++) begin
      if (exp_live[t] && (exp_seen[t] == 0)) begin
        exp_live[t] = 1'b0;
        pending--;
      end
    end
  endtask

  initial begin
    row_t r;
    int   cyc;
    int   bad_tag;
    rst_n = 1'b0;
    flush = 1'b0;
    dispatch_valid = 1'b0;
    dispatch_in = '0;
    serialize = 1'b0;
    head_tag = '0;
    build_table();
    prepare_expected();
    table_len = rows.size();
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    cyc = 0;
    for (int i = 0; i < table_len; i++) begin
      r = rows[i];
      @(posedge clk);
      #1 apply_row(r, i);
      @(negedge clk);
      check_stall(stall, r.exp_stall, i);
      sample_lanes(i);
      if (r.flush) begin
        drop_pending();
      end
      prev_ser = r.ser;
      prev_head = r.head;
      cyc = i + 1;
    end
    // Drain, then a few quiet cycles to catch duplicates
    idle_row(1'b0, NO_HEAD, 1'b0, 1'b0);
    r = rows[table_len];
    while (pending > 0) begin
      @(posedge clk);
      #1 apply_row(r, cyc);
      @(negedge clk);
      sample_lanes(cyc);
      prev_ser = 1'b0;
      cyc++;
    end
    repeat (4) begin
      @(posedge clk);
      #1 apply_row(r, cyc);
      @(negedge clk);
      sample_lanes(cyc);
      cyc++;
    end
    bad_tag = -1;
    for (int t = 0; t < N_TAGS; t++) begin
      if ((bad_tag < 0) && exp_live[t] && (exp_seen[t] != 1)) begin
        bad_tag = t;
      end
    end
    if (bad_tag >= 0) begin
      abort_run($sformatf("Tag %0d was seen %0d times instead of once",
                          bad_tag, exp_seen[bad_tag]));
    end else begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

// ==== include/ooo_macros.svh ====
`ifndef OOO_MACROS_SVH
`define OOO_MACROS_SVH

// Reservation station size and index width
`define OOO_RS_DEPTH 8
`define OOO_RS_IDX_W 3

// Destination tag space, wraps after 64 micro-ops
`define OOO_TAG_W 6

// Operand and result width
`define OOO_DATA_W 32

// Each ALU owns one CDB lane, so the two counts match
`define OOO_CDB_W 2
`define OOO_ISSUE_W 2

`endif

// ==== logic/alu_exec.sv ====
`timescale 1ns/1ps
`include "ooo_macros.svh"

module alu_exec (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            flush,
  input  logic            issue_valid,
  input  ooo_pkg::issue_t issue_in,
  output ooo_pkg::cdb_t   cdb_out
);

  logic [`OOO_DATA_W-1:0] op_a;
  logic [`OOO_DATA_W-1:0] op_b;
  logic [`OOO_DATA_W-1:0] result;
  logic [4:0]             shamt;
  logic                   valid_q;
  logic [`OOO_TAG_W-1:0]  tag_q;
  logic [`OOO_DATA_W-1:0] value_q;

  assign op_a  = issue_in.v1;
  assign op_b  = issue_in.v2;
  assign shamt = op_b[4:0];

  always_comb begin
    case (issue_in.uop.op)
      ooo_pkg::ALU_ADD: result = op_a + op_b;
      ooo_pkg::ALU_SUB: result = op_a - op_b;
      ooo_pkg::ALU_AND: result = op_a & op_b;
      ooo_pkg::ALU_OR:  result = op_a | op_b;
      ooo_pkg::ALU_XOR: result = op_a ^ op_b;
      ooo_pkg::ALU_SLL: result = op_a << shamt;
      ooo_pkg::ALU_SRL: result = op_a >> shamt;
      // Signed compare
      ooo_pkg::ALU_SLT: result = {{(`OOO_DATA_W-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default:          result = '0;
    endcase
  end

  // In-flight result is dropped on flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= issue_valid && !flush;
    end
  end

  always_ff @(posedge clk) begin
    if (issue_valid) begin
      tag_q   <= issue_in.dst_tag;
      value_q <= result;
    end
  end

  assign cdb_out.valid = valid_q;
  assign cdb_out.tag   = tag_q;
  assign cdb_out.value = value_q;

endmodule

// ==== logic/issue_select.sv ====
`timescale 1ns/1ps
`include "ooo_macros.svh"

module issue_select (
  input  logic [`OOO_RS_DEPTH-1:0] ready_mask,
  output logic [`OOO_RS_DEPTH-1:0] issue_grant,
  output logic [`OOO_RS_IDX_W-1:0] issue_idx [`OOO_ISSUE_W],
  output logic                     issue_valid [`OOO_ISSUE_W]
);

  localparam int IDX_W = `OOO_RS_IDX_W;

  // Each port takes the lowest ready entry not claimed by an earlier port
  always_comb begin
    logic [`OOO_RS_DEPTH-1:0] remaining;
    remaining   = ready_mask;
    issue_grant = '0;
    for (int p = 0; p < `OOO_ISSUE_W; p++) begin
      issue_valid[p] = 1'b0;
      issue_idx[p]   = '0;
      for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
        if (remaining[i] && !issue_valid[p]) begin
          issue_valid[p] = 1'b1;
          issue_idx[p]   = IDX_W'(i);
        end
      end
      if (issue_valid[p]) begin
        remaining[issue_idx[p]]   = 1'b0;
        issue_grant[issue_idx[p]] = 1'b1;
      end
    end
  end

endmodule

// ==== logic/ooo_issue_top.sv ====
`timescale 1ns/1ps
`include "ooo_macros.svh"

module ooo_issue_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  flush,
  input  logic                  dispatch_valid,
  input  ooo_pkg::dispatch_t    dispatch_in,
  input  logic                  serialize,
  input  logic [`OOO_TAG_W-1:0] head_tag,
  output logic                  stall,
  output ooo_pkg::cdb_t         cdb [`OOO_CDB_W]
);

  logic [`OOO_RS_DEPTH-1:0] busy_vector;
  logic [`OOO_RS_DEPTH-1:0] entry_wen;
  ooo_pkg::rs_entry_t       entry_in;
  logic [`OOO_RS_DEPTH-1:0] ready_mask;
  logic [`OOO_RS_DEPTH-1:0] issue_grant;
  logic [`OOO_RS_IDX_W-1:0] issue_idx [`OOO_ISSUE_W];
  logic                     issue_valid [`OOO_ISSUE_W];
  ooo_pkg::issue_t          issue_out [`OOO_ISSUE_W];

  rs_dispatch dispatch_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .dispatch_valid(dispatch_valid), .dispatch_in(dispatch_in),
    .busy_vector(busy_vector), .stall(stall),
    .entry_wen(entry_wen), .entry_in(entry_in)
  );

  reservation_station rs_i (
    .clk(clk), .rst_n(rst_n), .flush(flush),
    .entry_wen(entry_wen), .entry_in(entry_in),
    .serialize(serialize), .head_tag(head_tag), .cdb(cdb),
    .issue_grant(issue_grant), .issue_idx(issue_idx),
    .ready_mask(ready_mask), .busy_vector(busy_vector), .issue_out(issue_out)
  );

  issue_select select_i (
    .ready_mask(ready_mask), .issue_grant(issue_grant),
    .issue_idx(issue_idx), .issue_valid(issue_valid)
  );

  // One ALU per issue port, each driving its own CDB lane
  for (genvar g = 0; g < `OOO_ISSUE_W; g++) begin : gen_alu
    alu_exec alu_i (
      .clk(clk), .rst_n(rst_n), .flush(flush),
      .issue_valid(issue_valid[g]), .issue_in(issue_out[g]), .cdb_out(cdb[g])
    );
  end

endmodule

// ==== logic/ooo_pkg.sv ====
`include "ooo_macros.svh"

package ooo_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLL = 3'd5,
    ALU_SRL = 3'd6,
    ALU_SLT = 3'd7
  } alu_op_e;

  // A source flagged absent counts as ready
  typedef struct packed {
    alu_op_e op;
    logic    has_rs1;
    logic    has_rs2;
  } uop_t;

  // Either a ready value or the tag of the producer it waits for
  typedef struct packed {
    logic [`OOO_DATA_W-1:0] value;
    logic [`OOO_TAG_W-1:0]  tag;
    logic                   ready;
  } src_t;

  typedef struct packed {
    uop_t uop;
    src_t src1;
    src_t src2;
  } dispatch_t;

  typedef struct packed {
    dispatch_t             disp;
    logic [`OOO_TAG_W-1:0] dst_tag;
  } rs_entry_t;

  typedef struct packed {
    uop_t                   uop;
    logic [`OOO_TAG_W-1:0]  dst_tag;
    logic [`OOO_DATA_W-1:0] v1;
    logic [`OOO_DATA_W-1:0] v2;
  } issue_t;

  typedef struct packed {
    logic                   valid;
    logic [`OOO_TAG_W-1:0]  tag;
    logic [`OOO_DATA_W-1:0] value;
  } cdb_t;

endpackage

// ==== logic/reservation_station.sv ====
`timescale 1ns/1ps
`include "ooo_macros.svh"

module reservation_station (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic [`OOO_RS_DEPTH-1:0] entry_wen,
  input  ooo_pkg::rs_entry_t       entry_in,
  input  logic                     serialize,
  input  logic [`OOO_TAG_W-1:0]    head_tag,
  input  ooo_pkg::cdb_t            cdb [`OOO_CDB_W],
  input  logic [`OOO_RS_DEPTH-1:0] issue_grant,
  input  logic [`OOO_RS_IDX_W-1:0] issue_idx [`OOO_ISSUE_W],
  output logic [`OOO_RS_DEPTH-1:0] ready_mask,
  output logic [`OOO_RS_DEPTH-1:0] busy_vector,
  output ooo_pkg::issue_t          issue_out [`OOO_ISSUE_W]
);

  logic [`OOO_RS_DEPTH-1:0] busy_q;
  logic [`OOO_RS_DEPTH-1:0] busy_d;
  ooo_pkg::rs_entry_t       entries_q [`OOO_RS_DEPTH];
  ooo_pkg::rs_entry_t       entries_d [`OOO_RS_DEPTH];
  ooo_pkg::rs_entry_t       entry_fwd;

  // Capture a waiting operand when a valid lane carries its tag
  function automatic ooo_pkg::src_t snoop(input ooo_pkg::src_t src,
                                          input ooo_pkg::cdb_t lanes [`OOO_CDB_W]);
    ooo_pkg::src_t res;
    res = src;
    if (!src.ready) begin
      for (int k = 0; k < `OOO_CDB_W; k++) begin
        if (lanes[k].valid && (lanes[k].tag == src.tag)) begin
          res.value = lanes[k].value;
          res.ready = 1'b1;
        end
      end
    end
    return res;
  endfunction

  // Incoming entry sees the CDB of its write cycle
  always_comb begin
    entry_fwd           = entry_in;
    entry_fwd.disp.src1 = snoop(entry_in.disp.src1, cdb);
    entry_fwd.disp.src2 = snoop(entry_in.disp.src2, cdb);
  end

  always_comb begin
    busy_d    = busy_q;
    entries_d = entries_q;
    for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
      if (issue_grant[i]) begin
        // Grant wins over a write to the same entry
        busy_d[i] = 1'b0;
      end else if (entry_wen[i]) begin
        busy_d[i]    = 1'b1;
        entries_d[i] = entry_fwd;
      end else if (busy_q[i]) begin
        entries_d[i].disp.src1 = snoop(entries_q[i].disp.src1, cdb);
        entries_d[i].disp.src2 = snoop(entries_q[i].disp.src2, cdb);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else if (flush) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_d;
    end
  end

  always_ff @(posedge clk) begin
    entries_q <= entries_d;
  end

  assign busy_vector = busy_q;

  // Ready when busy, present sources ready, and the serialize head matches
  always_comb begin
    logic src1_ok;
    logic src2_ok;
    logic head_ok;
    src1_ok = 1'b0;
    src2_ok = 1'b0;
    head_ok = 1'b0;
    ready_mask = '0;
    for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
      src1_ok = !entries_q[i].disp.uop.has_rs1 || entries_q[i].disp.src1.ready;
      src2_ok = !entries_q[i].disp.uop.has_rs2 || entries_q[i].disp.src2.ready;
      head_ok = !serialize || (entries_q[i].dst_tag == head_tag);
      ready_mask[i] = busy_q[i] && src1_ok && src2_ok && head_ok;
    end
  end

  // Read-out per issue port
  always_comb begin
    for (int p = 0; p < `OOO_ISSUE_W; p++) begin
      issue_out[p].uop     = entries_q[issue_idx[p]].disp.uop;
      issue_out[p].dst_tag = entries_q[issue_idx[p]].dst_tag;
      issue_out[p].v1      = entries_q[issue_idx[p]].disp.src1.value;
      issue_out[p].v2      = entries_q[issue_idx[p]].disp.src2.value;
    end
  end

endmodule

// ==== logic/rs_dispatch.sv ====
`timescale 1ns/1ps
`include "ooo_macros.svh"

module rs_dispatch (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     flush,
  input  logic                     dispatch_valid,
  input  ooo_pkg::dispatch_t       dispatch_in,
  input  logic [`OOO_RS_DEPTH-1:0] busy_vector,
  output logic                     stall,
  output logic [`OOO_RS_DEPTH-1:0] entry_wen,
  output ooo_pkg::rs_entry_t       entry_in
);

  logic [`OOO_TAG_W-1:0]   tag_q;
  logic [`OOO_RS_DEPTH-1:0] free_onehot;
  logic                     accept;

  // Station is full when every entry is busy
  assign stall = &busy_vector;

  // Lowest clear bit of busy_vector, one-hot
  always_comb begin
    free_onehot = '0;
    for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy_vector[i]) begin
        free_onehot = '0;
        free_onehot[i] = 1'b1;
      end
    end
  end

  // A flush empties the station at the same edge, so nothing is written then
  assign accept = dispatch_valid && !stall && !flush;

  assign entry_wen = accept ? free_onehot : '0;

  always_comb begin
    entry_in         = '0;
    entry_in.disp    = dispatch_in;
    entry_in.dst_tag = tag_q;
  end

  // Tag counter wraps and survives a flush
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tag_q <= '0;
    end else if (accept) begin
      tag_q <= tag_q + 1'b1;
    end
  end

endmodule
